// File: design/rv_dec_params.svh
// Width and size macros for the RV32I decode stage, included by the package and every RTL file
`ifndef RV_DEC_PARAMS_SVH
`define RV_DEC_PARAMS_SVH

// Data path and address width
// Also the width of pc, immediate and register words
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Bits needed to address one register
// Must satisfy 2**REG_IDX_W == REG_COUNT
`define REG_IDX_W 5

// Notes
// The instruction word is always 32 bits in RV32I.
// Format field widths stay fixed in the package,
// only the register index width follows REG_IDX_W.
// XLEN other than 32 is not a supported configuration
// for the immediate layout.

`endif

// File: design/rv_dec_pkg.sv
// Shared types of the decode stage: funct3 codes, instruction format views and port structs
`default_nettype none

`include "rv_dec_params.svh"

package rv_dec_pkg;

	// Branch conditions as carried in funct3
	typedef enum logic [2:0] {
		f3_beq  = 3'b000,
		f3_bne  = 3'b001,
		f3_blt  = 3'b100,
		f3_bge  = 3'b101,
		f3_bltu = 3'b110,
		f3_bgeu = 3'b111
	} funct3_t;

	// Register to register
	typedef struct packed {
		logic [6:0]            funct7;
		logic [`REG_IDX_W-1:0] rs2;
		logic [`REG_IDX_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [`REG_IDX_W-1:0] rd;
		logic [6:0]            opcode;
	} instr_r_t;

	// Loads, op-imm, jalr
	typedef struct packed {
		logic [11:0]           imm_11_0;
		logic [`REG_IDX_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [`REG_IDX_W-1:0] rd;
		logic [6:0]            opcode;
	} instr_i_t;

	// Stores, immediate split around rs fields
	typedef struct packed {
		logic [6:0]            imm_11_5;
		logic [`REG_IDX_W-1:0] rs2;
		logic [`REG_IDX_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [4:0]            imm_4_0;
		logic [6:0]            opcode;
	} instr_s_t;

	// Conditional branches, offset in halfwords
	typedef struct packed {
		logic                  imm_12;
		logic [5:0]            imm_10_5;
		logic [`REG_IDX_W-1:0] rs2;
		logic [`REG_IDX_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [3:0]            imm_4_1;
		logic                  imm_11;
		logic [6:0]            opcode;
	} instr_b_t;

	// Lui and auipc
	typedef struct packed {
		logic [19:0]           imm_31_12;
		logic [`REG_IDX_W-1:0] rd;
		logic [6:0]            opcode;
	} instr_u_t;

	// Jal, scrambled 20-bit offset
	typedef struct packed {
		logic                  imm_20;
		logic [9:0]            imm_10_1;
		logic                  imm_11;
		logic [7:0]            imm_19_12;
		logic [`REG_IDX_W-1:0] rd;
		logic [6:0]            opcode;
	} instr_j_t;

	// One fetched word, six ways to read it
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_s_t s;
		instr_b_t b;
		instr_u_t u;
		instr_j_t j;
	} instr_u;

	// From the upstream opcode decoder
	typedef struct packed {
		logic branch;
		logic jal;
		logic jalr;
	} dec_ctrl_t;

	// Writeback strobe into the register file
	typedef struct packed {
		logic                  en;
		logic [`REG_IDX_W-1:0] rd;
		logic [`XLEN-1:0]      data;
	} wb_write_t;

	// Everything execute needs
	typedef struct packed {
		logic [`XLEN-1:0]      pc;
		logic [`XLEN-1:0]      imm;
		logic [`XLEN-1:0]      rs1_data;
		logic [`XLEN-1:0]      rs2_data;
		logic [`REG_IDX_W-1:0] rd;
		logic [`REG_IDX_W-1:0] rs1;
		logic [`REG_IDX_W-1:0] rs2;
	} ex_operands_t;

	// Redirect toward fetch
	typedef struct packed {
		logic             taken;
		logic [`XLEN-1:0] target;
	} branch_res_t;

endpackage

`default_nettype wire

// File: design/imm_gen.sv
// Immediate generator, combinational, rebuilds the sign-extended operand of an RV32I word
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_params.svh"

module imm_gen import rv_dec_pkg::*; (
	input  instr_u           instr,
	output logic [`XLEN-1:0] imm
);

	// Major opcodes that carry an immediate
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_op_imm = 7'b0010011;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;

	// Instruction bit 31, sign of every format
	logic sign;

	// Opcode sits in the same place in all views
	assign sign = instr.r.funct7[6];

	always_comb begin
		unique case (instr.r.opcode)
			// I format, 12 bits straight
			op_load, op_op_imm, op_jalr: begin
				imm = {{(`XLEN-12){sign}}, instr.i.imm_11_0};
			end
			// S format, two pieces
			op_store: begin
				imm = {{(`XLEN-12){sign}}, instr.s.imm_11_5, instr.s.imm_4_0};
			end
			// B format, bit 0 implied zero
			op_branch: begin
				imm = {{(`XLEN-13){sign}}, instr.b.imm_12, instr.b.imm_11,
					instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
			end
			// U format, upper bits, low half zero-filled
			op_lui, op_auipc: begin
				imm = {instr.u.imm_31_12, 12'b0};
			end
			// J format, bit 0 implied zero
			op_jal: begin
				imm = {{(`XLEN-21){sign}}, instr.j.imm_20, instr.j.imm_19_12,
					instr.j.imm_11, instr.j.imm_10_1, 1'b0};
			end
			// R format and anything unknown
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/branch_unit.sv
// Branch unit, combinational, resolves the branch or jump decision and target for fetch
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_params.svh"

module branch_unit import rv_dec_pkg::*; (
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] imm,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	input  funct3_t          funct3,
	input  dec_ctrl_t        dec_ctrl,
	output branch_res_t      branch
);

	// Raw comparisons
	logic eq;
	logic lt_s;
	logic lt_u;

	// Condition selected by funct3
	logic cond_met;

	// Candidate targets
	logic [`XLEN-1:0] pc_sum;
	logic [`XLEN-1:0] reg_sum;

	assign eq   = (rs1_data == rs2_data);
	assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
	assign lt_u = (rs1_data < rs2_data);

	// Six conditions, the rest never hold
	always_comb begin
		case (funct3)
			f3_beq:  cond_met = eq;
			f3_bne:  cond_met = !eq;
			f3_blt:  cond_met = lt_s;
			f3_bge:  cond_met = !lt_s;
			f3_bltu: cond_met = lt_u;
			f3_bgeu: cond_met = !lt_u;
			default: cond_met = 1'b0;
		endcase
	end

	// Jumps are unconditional
	assign branch.taken = dec_ctrl.jal | dec_ctrl.jalr | (dec_ctrl.branch & cond_met);

	// Pc-relative for branches and jal
	assign pc_sum = pc + imm;

	// Register-relative for jalr
	assign reg_sum = rs1_data + imm;

	// Jalr drops bit 0 of the sum
	assign branch.target = dec_ctrl.jalr ? {reg_sum[`XLEN-1:1], 1'b0} : pc_sum;

endmodule

`default_nettype wire

// File: design/register_file.sv
// Integer register file, two combinational read ports and one clocked writeback port
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_params.svh"

module register_file import rv_dec_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`REG_IDX_W-1:0] rs1,
	input  logic [`REG_IDX_W-1:0] rs2,
	input  wb_write_t             wb,
	output logic [`XLEN-1:0]      rs1_data,
	output logic [`XLEN-1:0]      rs2_data
);

	// Architectural state
	logic [`XLEN-1:0] regs [`REG_COUNT];

	// Whole array clears on reset
	// x0 is never a write target
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `REG_COUNT; k++) begin
				regs[k] <= '0;
			end
		end else if (wb.en && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Reads see the stored word only
	// A write lands after the edge, no bypass
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: design/dec_stage.sv
// Decode stage top, splits the instruction word and feeds execute and the fetch redirect
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_params.svh"

module dec_stage import rv_dec_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  instr_u           instr,
	input  logic [`XLEN-1:0] pc,
	input  dec_ctrl_t        dec_ctrl,
	input  wb_write_t        wb,
	output ex_operands_t     ex,
	output branch_res_t      branch
);

	// Decoded fields
	logic [`REG_IDX_W-1:0] rs1_idx;
	logic [`REG_IDX_W-1:0] rs2_idx;
	logic [`REG_IDX_W-1:0] rd_idx;
	funct3_t               funct3;

	// Block outputs
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;

	// Index fields share positions across formats
	// R view covers all three
	assign rs1_idx = instr.r.rs1;
	assign rs2_idx = instr.r.rs2;
	assign rd_idx  = instr.r.rd;

	// Only meaningful for branches
	assign funct3 = funct3_t'(instr.b.funct3);

	// Immediate from the format chosen by opcode
	imm_gen i_imm_gen (
		.instr (instr),
		.imm   (imm)
	);

	// Read ports follow the decoded indices
	// Write port is the writeback strobe as is
	register_file i_register_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (rs1_idx),
		.rs2      (rs2_idx),
		.wb       (wb),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	// Branch decision in the same cycle
	branch_unit i_branch_unit (
		.pc       (pc),
		.imm      (imm),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.funct3   (funct3),
		.dec_ctrl (dec_ctrl),
		.branch   (branch)
	);

	// Operand bundle toward execute
	// Indices pass along for forwarding downstream
	assign ex = '{
		pc:       pc,
		imm:      imm,
		rs1_data: rs1_data,
		rs2_data: rs2_data,
		rd:       rd_idx,
		rs1:      rs1_idx,
		rs2:      rs2_idx
	};

endmodule

`default_nettype wire

// File: tests/dec_stage_props.sv
// Bound assertion checker for the decode stage top, counts and flags rule violations
`timescale 1ns/1ns
`default_nettype none

module dec_stage_props import rv_dec_pkg::*; (
	input logic         clk,
	input logic         rst_n,
	input dec_ctrl_t    dec_ctrl,
	input ex_operands_t ex,
	input branch_res_t  branch
);

	// Read by the testbench at the end of the run
	int fail_count = 0;

	// Index zero on either port reads zero
	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(ex.rs1 != '0 || ex.rs1_data == '0) && (ex.rs2 != '0 || ex.rs2_data == '0))
		else begin
			fail_count++;
			$error("x0 read returned a nonzero value");
		end

	// No redirect without a control bit
	a_taken_needs_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
		branch.taken |-> (dec_ctrl != '0))
		else begin
			fail_count++;
			$error("branch taken while all control bits are clear");
		end

	// Register-relative targets are halfword aligned
	a_jalr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		dec_ctrl.jalr |-> !branch.target[0])
		else begin
			fail_count++;
			$error("jalr target has bit 0 set");
		end

	// Jal never falls through
	a_jal_taken: assert property (@(posedge clk) disable iff (!rst_n)
		dec_ctrl.jal |-> branch.taken)
		else begin
			fail_count++;
			$error("jal not taken");
		end

endmodule

bind dec_stage dec_stage_props i_dec_stage_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.dec_ctrl (dec_ctrl),
	.ex       (ex),
	.branch   (branch)
);

`default_nettype wire

// File: tests/dec_stage_tb.sv
// Table-driven testbench for the decode stage that runs as top with a shadow register model
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_params.svh"

module dec_stage_tb import rv_dec_pkg::*; ();

	localparam int half_period  = 4;
	localparam int reset_cycles = 16;

	// Major opcodes used to build words
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_op_imm = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;

	localparam dec_ctrl_t ctrl_none   = '{branch: 1'b0, jal: 1'b0, jalr: 1'b0};
	localparam dec_ctrl_t ctrl_branch = '{branch: 1'b1, jal: 1'b0, jalr: 1'b0};
	localparam dec_ctrl_t ctrl_jal    = '{branch: 1'b0, jal: 1'b1, jalr: 1'b0};
	localparam dec_ctrl_t ctrl_jalr   = '{branch: 1'b0, jal: 1'b0, jalr: 1'b1};

	// Conditions, operand pairs (equal, signed-less, unsigned-less) and offsets
	localparam logic [2:0]  branch_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
	localparam logic [4:0]  pair_rs1 [3]  = '{5'd8, 5'd10, 5'd11};
	localparam logic [4:0]  pair_rs2 [3]  = '{5'd9, 5'd11, 5'd10};
	localparam logic [12:0] branch_off [3] = '{13'h0010, 13'h1FF8, 13'h0FFE};

	typedef struct {
		string       name;
		logic [31:0] instr;
		logic [31:0] pc;
		dec_ctrl_t   ctrl;
		logic        wen;
		logic [4:0]  wrd;
		logic [31:0] wdata;
	} entry_t;

	logic             clk;
	logic             rst_n;
	instr_u           instr;
	logic [`XLEN-1:0] pc;
	dec_ctrl_t        dec_ctrl;
	wb_write_t        wb;
	ex_operands_t     ex;
	branch_res_t      branch;

	entry_t      tests [$];
	logic [31:0] shadow [`REG_COUNT];
	int          seed = 48441;
	int          cycles = 0;
	int          cycle_limit;

	dec_stage i_dec_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.instr    (instr),
		.pc       (pc),
		.dec_ctrl (dec_ctrl),
		.wb       (wb),
		.ex       (ex),
		.branch   (branch)
	);

	always #half_period clk = ~clk;

	// Run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("TESTBENCH FAILED");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", cycle_limit);
		end
	end

	// Word builders for each encoding format
	function automatic logic [31:0] r_word(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
		logic [4:0] rs1, logic [4:0] rs2, logic [6:0] f7);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_word(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
		logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_word(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] u_word(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_word(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	// Immediate by format taken straight from the bit positions of the word
	function automatic logic [31:0] imm_of_word(logic [31:0] w);
		case (w[6:0])
			op_load, op_op_imm, op_jalr: return {{20{w[31]}}, w[31:20]};
			op_store: return {{20{w[31]}}, w[31:25], w[11:7]};
			op_branch: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			op_lui, op_auipc: return {w[31:12], 12'h000};
			op_jal: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic condition_holds(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			3'b111: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] jump_target(dec_ctrl_t ctrl, logic [31:0] pc_in,
		logic [31:0] a, logic [31:0] imm);
		logic [31:0] sum;
		sum = a + imm;
		if (ctrl.jalr) begin
			return {sum[31:1], 1'b0};
		end
		return pc_in + imm;
	endfunction

	task automatic add_entry(string name, logic [31:0] word, dec_ctrl_t ctrl, logic wen,
		logic [4:0] wrd, logic [31:0] wdata);
		entry_t e;
		e.name  = name;
		e.instr = word;
		e.pc    = 32'h0000_2000 + 32'(4 * tests.size());
		e.ctrl  = ctrl;
		e.wen   = wen;
		e.wrd   = wrd;
		e.wdata = wdata;
		tests.push_back(e);
	endtask

	task automatic add_read(string name, logic [31:0] word, dec_ctrl_t ctrl);
		add_entry(name, word, ctrl, 1'b0, 5'd0, 32'h0);
	endtask

	task automatic build_table();
		// Reset scan of every register through both read ports
		for (int k = 0; k < 16; k++) begin
			add_read("reset_scan", r_word(op_op, 5'd0, 3'd0, 5'(2 * k), 5'(2 * k + 1), 7'd0),
				ctrl_none);
			add_read("reset_scan_swap", r_word(op_op, 5'd0, 3'd0, 5'(2 * k + 1), 5'(2 * k),
				7'd0), ctrl_none);
		end
		// Random data into x1..x7 read back on both ports
		for (int k = 1; k < 8; k++) begin
			add_entry("write_random", r_word(op_op, 5'(k), 3'd0, 5'(k), 5'(k), 7'd0), ctrl_none,
				1'b1, 5'(k), $random(seed));
		end
		// Known operands for compares and jalr
		add_entry("write_x8", r_word(op_op, 5'd8, 3'd0, 5'd8, 5'd8, 7'd0), ctrl_none, 1'b1, 5'd8,
			32'd5);
		add_entry("write_x9", r_word(op_op, 5'd9, 3'd0, 5'd9, 5'd9, 7'd0), ctrl_none, 1'b1, 5'd9,
			32'd5);
		add_entry("write_x10", r_word(op_op, 5'd10, 3'd0, 5'd10, 5'd10, 7'd0), ctrl_none, 1'b1,
			5'd10, 32'hFFFF_FFF0);
		add_entry("write_x11", r_word(op_op, 5'd11, 3'd0, 5'd11, 5'd11, 7'd0), ctrl_none, 1'b1,
			5'd11, 32'd7);
		add_entry("write_x14", r_word(op_op, 5'd14, 3'd0, 5'd14, 5'd14, 7'd0), ctrl_none, 1'b1,
			5'd14, 32'h0000_1001);
		// Ignored writes
		add_entry("write_x0", r_word(op_op, 5'd0, 3'd0, 5'd0, 5'd0, 7'd0), ctrl_none, 1'b1, 5'd0,
			$random(seed));
		add_entry("write_disabled", r_word(op_op, 5'd3, 3'd0, 5'd3, 5'd3, 7'd0), ctrl_none, 1'b0,
			5'd3, 32'hDEAD_BEEF);
		add_read("readback_x1_x2", r_word(op_op, 5'd15, 3'd0, 5'd1, 5'd2, 7'd0), ctrl_none);
		add_read("readback_x6_x7", r_word(op_op, 5'd16, 3'd0, 5'd6, 5'd7, 7'd0), ctrl_none);
		// One word per format with negative immediates where the format has a sign
		add_read("fmt_i_addi", i_word(op_op_imm, 5'd12, 3'd0, 5'd1, 12'hFFB), ctrl_none);
		add_read("fmt_i_load", i_word(op_load, 5'd13, 3'd2, 5'd2, 12'h7FC), ctrl_none);
		add_read("fmt_s_store", s_word(5'd1, 5'd2, 12'hFEC), ctrl_none);
		add_read("fmt_u_lui", u_word(op_lui, 5'd17, 20'hABCDE), ctrl_none);
		add_read("fmt_u_auipc", u_word(op_auipc, 5'd18, 20'h00012), ctrl_none);
		add_read("fmt_r_add", r_word(op_op, 5'd19, 3'd0, 5'd4, 5'd5, 7'h20), ctrl_none);
		// Every condition against every operand pair
		for (int c = 0; c < 6; c++) begin
			for (int p = 0; p < 3; p++) begin
				add_read($sformatf("branch_f3_%b_pair_%0d", branch_f3[c], p),
					b_word(branch_f3[c], pair_rs1[p], pair_rs2[p], branch_off[p]), ctrl_branch);
			end
		end
		add_read("jal_back", j_word(5'd1, 21'h1FF800), ctrl_jal);
		add_read("jal_fwd", j_word(5'd5, 21'h001234), ctrl_jal);
		// x14 is odd, so the sum may need bit 0 cleared
		add_read("jalr_odd_sum", i_word(op_jalr, 5'd1, 3'd0, 5'd14, 12'h004), ctrl_jalr);
		add_read("jalr_odd_sum_2", i_word(op_jalr, 5'd1, 3'd0, 5'd14, 12'h010), ctrl_jalr);
		add_read("jalr_neg", i_word(op_jalr, 5'd0, 3'd0, 5'd14, 12'hFFF), ctrl_jalr);
	endtask

	task automatic check_value(string test, string field, logic [31:0] expected,
		logic [31:0] actual);
		if (actual !== expected) begin
			$display("Mismatch in %s, %s: expected %h, actual %h", test, field, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "Stopping at the first wrong value");
		end
	endtask

	// Expected ex and branch from the shadow registers
	task automatic check_outputs(entry_t e, string phase);
		string       tag;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic        taken;
		tag   = {e.name, " ", phase};
		imm   = imm_of_word(e.instr);
		a     = shadow[e.instr[19:15]];
		b     = shadow[e.instr[24:20]];
		taken = e.ctrl.jal | e.ctrl.jalr | (e.ctrl.branch & condition_holds(e.instr[14:12], a, b));
		check_value(tag, "ex.pc", e.pc, ex.pc);
		check_value(tag, "ex.imm", imm, ex.imm);
		check_value(tag, "ex.rs1_data", a, ex.rs1_data);
		check_value(tag, "ex.rs2_data", b, ex.rs2_data);
		check_value(tag, "ex.rd", 32'(e.instr[11:7]), 32'(ex.rd));
		check_value(tag, "ex.rs1", 32'(e.instr[19:15]), 32'(ex.rs1));
		check_value(tag, "ex.rs2", 32'(e.instr[24:20]), 32'(ex.rs2));
		check_value(tag, "branch.taken", 32'(taken), 32'(branch.taken));
		check_value(tag, "branch.target", jump_target(e.ctrl, e.pc, a, imm), branch.target);
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		instr    = '0;
		pc       = '0;
		dec_ctrl = '0;
		wb       = '0;
		for (int r = 0; r < `REG_COUNT; r++) begin
			shadow[r] = 32'h0;
		end
		build_table();
		cycle_limit = reset_cycles + 2 * tests.size() + 20;
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		foreach (tests[n]) begin
			instr    = tests[n].instr;
			pc       = tests[n].pc;
			dec_ctrl = tests[n].ctrl;
			wb       = '{en: tests[n].wen, rd: tests[n].wrd, data: tests[n].wdata};
			// Same-cycle read still sees the old word
			#2;
			check_outputs(tests[n], "before edge");
			@(posedge clk);
			if (tests[n].wen && tests[n].wrd != 5'd0) begin
				shadow[tests[n].wrd] = tests[n].wdata;
			end
			#3;
			check_outputs(tests[n], "after edge");
			@(negedge clk);
		end
		if (i_dec_stage.i_dec_stage_props.fail_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$fatal(1, "Bound assertions reported failures");
		end
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/rv_dec_pkg.sv
design/imm_gen.sv
design/branch_unit.sv
design/register_file.sv
design/dec_stage.sv
tests/dec_stage_props.sv
tests/dec_stage_tb.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= dec_stage_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
# Keep running after an assertion error so the testbench reports the result
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
